// ==== bank_pkg.sv ====
package bank_pkg;

  // Bank geometry.
  localparam int unsigned NUM_BANKS   = 4;
  localparam int unsigned ADDR_W      = 16;
  localparam int unsigned DATA_W      = 64;
  localparam int unsigned STRB_W      = DATA_W / 8;
  localparam int unsigned BANK_DATA_W = DATA_W / NUM_BANKS;
  localparam int unsigned BANK_STRB_W = BANK_DATA_W / 8;
  localparam int unsigned BANK_BYTES  = BANK_STRB_W;
  localparam int unsigned WIDE_BYTES  = STRB_W;
  localparam int unsigned BANK_WORDS  = 64;

  // Byte offset bits inside one wide word.
  localparam int unsigned WIDE_OFFS_W = $clog2(WIDE_BYTES);
  // Word index bits inside one bank.
  localparam int unsigned WORD_IDX_W  = $clog2(BANK_WORDS);

  // Queue depths.
  localparam int unsigned REQ_FIFO_DEPTH  = 2;
  localparam int unsigned RESP_FIFO_DEPTH = 2;
  // Outstanding transactions tracked by the dead mask queue.
  localparam int unsigned MAX_TRANS       = 2;

  // One bank request item: write enable, address, data, strobe.
  localparam int unsigned REQ_ITEM_W = 1 + ADDR_W + BANK_DATA_W + BANK_STRB_W;

  // Wide side.
  typedef logic [ADDR_W-1:0]      addr_t;
  typedef logic [DATA_W-1:0]      data_t;
  typedef logic [STRB_W-1:0]      strb_t;

  // Bank side.
  typedef logic [BANK_DATA_W-1:0] bank_data_t;
  typedef logic [BANK_STRB_W-1:0] bank_strb_t;

  // One bit per bank.
  typedef logic [NUM_BANKS-1:0]   bank_mask_t;

endpackage

// ==== bank_sram.sv ====
`timescale 1ns/1ps

module bank_sram import bank_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       req_i,
  input  logic       we_i,
  input  addr_t      addr_i,
  input  bank_data_t wdata_i,
  input  bank_strb_t strb_i,
  output logic       gnt_o,
  output logic       rvalid_o,
  output bank_data_t rdata_o
);

  bank_data_t            mem_q [BANK_WORDS];
  logic [WORD_IDX_W-1:0] word_idx;
  logic                  busy_q;
  logic                  access;

  // Word index is the address over the wide word size, wrapped.
  assign word_idx = addr_i[WIDE_OFFS_W +: WORD_IDX_W];

  // Idle bank takes a request.
  assign gnt_o  = ~busy_q;
  assign access = req_i & gnt_o;

  // Control state.
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q   <= 1'b0;
      rvalid_o <= 1'b0;
    end else begin
      // Second cycle of the access.
      busy_q   <= access;
      // Response at the end of the busy cycle.
      rvalid_o <= busy_q;
    end
  end

  // Array and read data.
  always_ff @(posedge clk_i) begin
    if (access) begin
      if (we_i) begin
        for (int b = 0; b < BANK_STRB_W; b++) begin
          // Strobed bytes only.
          if (strb_i[b]) begin
            mem_q[word_idx][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end else begin
        rdata_o <= mem_q[word_idx];
      end
    end
  end

  // A slice that waits for the bank keeps its request and payload.
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
                   req_i && !gnt_o |=> req_i && $stable({we_i, addr_i, wdata_i, strb_i}))
    else $error("bank_sram: request changed while the bank was busy");

endmodule

// ==== bank_top.sv ====
`timescale 1ns/1ps

module bank_top import bank_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  req_i,
  input  logic  we_i,
  input  addr_t addr_i,
  input  data_t wdata_i,
  input  strb_t strb_i,
  output logic  gnt_o,
  output logic  rvalid_o,
  output data_t rdata_o
);

  // Bank request side.
  bank_mask_t                 bank_req;
  bank_mask_t                 bank_we;
  bank_mask_t                 bank_gnt;
  addr_t      [NUM_BANKS-1:0] bank_addr;
  bank_data_t [NUM_BANKS-1:0] bank_wdata;
  bank_strb_t [NUM_BANKS-1:0] bank_strb;

  // Bank response side.
  bank_mask_t                 bank_rvalid;
  bank_data_t [NUM_BANKS-1:0] bank_rdata;

  // Splitter to joiner.
  bank_mask_t                 resp_room;
  logic                       dead_full;
  logic                       dead_push;
  bank_mask_t                 dead_mask;

  mem_split u_split (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .req_i        (req_i),
    .we_i         (we_i),
    .addr_i       (addr_i),
    .wdata_i      (wdata_i),
    .strb_i       (strb_i),
    .gnt_o        (gnt_o),
    .resp_room_i  (resp_room),
    .dead_full_i  (dead_full),
    .dead_push_o  (dead_push),
    .dead_mask_o  (dead_mask),
    .bank_req_o   (bank_req),
    .bank_we_o    (bank_we),
    .bank_addr_o  (bank_addr),
    .bank_wdata_o (bank_wdata),
    .bank_strb_o  (bank_strb),
    .bank_gnt_i   (bank_gnt)
  );

  // One narrow bank per slice.
  for (genvar i = 0; i < NUM_BANKS; i++) begin : gen_bank
    bank_sram u_bank (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .req_i    (bank_req[i]),
      .we_i     (bank_we[i]),
      .addr_i   (bank_addr[i]),
      .wdata_i  (bank_wdata[i]),
      .strb_i   (bank_strb[i]),
      .gnt_o    (bank_gnt[i]),
      .rvalid_o (bank_rvalid[i]),
      .rdata_o  (bank_rdata[i])
    );
  end

  resp_join u_join (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .bank_rvalid_i (bank_rvalid),
    .bank_rdata_i  (bank_rdata),
    .resp_room_o   (resp_room),
    .dead_push_i   (dead_push),
    .dead_mask_i   (dead_mask),
    .dead_full_o   (dead_full),
    .rvalid_o      (rvalid_o),
    .rdata_o       (rdata_o)
  );

endmodule

// ==== mem_split.sv ====
`timescale 1ns/1ps

module mem_split import bank_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       req_i,
  input  logic                       we_i,
  input  addr_t                      addr_i,
  input  data_t                      wdata_i,
  input  strb_t                      strb_i,
  output logic                       gnt_o,
  input  bank_mask_t                 resp_room_i,
  input  logic                       dead_full_i,
  output logic                       dead_push_o,
  output bank_mask_t                 dead_mask_o,
  output bank_mask_t                 bank_req_o,
  output bank_mask_t                 bank_we_o,
  output addr_t      [NUM_BANKS-1:0] bank_addr_o,
  output bank_data_t [NUM_BANKS-1:0] bank_wdata_o,
  output bank_strb_t [NUM_BANKS-1:0] bank_strb_o,
  input  bank_mask_t                 bank_gnt_i
);

  addr_t                                base_addr;
  logic                                 req_fire;
  bank_mask_t                           fifo_ready;
  bank_mask_t                           head_valid;
  bank_mask_t                           head_pop;
  bank_mask_t                           hidden;
  logic [NUM_BANKS-1:0][REQ_ITEM_W-1:0] slice_in;
  logic [NUM_BANKS-1:0][REQ_ITEM_W-1:0] slice_out;

  // Wide word base address.
  assign base_addr = {addr_i[ADDR_W-1:WIDE_OFFS_W], {WIDE_OFFS_W{1'b0}}};

  // Grant needs room in every bank queue, every response queue and the mask queue.
  assign gnt_o = (&fifo_ready) & (&resp_room_i) & ~dead_full_i;

  assign req_fire = req_i & gnt_o;

  // One mask entry per accepted request.
  assign dead_push_o = req_fire;

  for (genvar i = 0; i < NUM_BANKS; i++) begin : gen_bank
    // Slice i sits i bank widths above the base.
    assign slice_in[i] = {
      we_i,
      addr_t'(base_addr + i * BANK_BYTES),
      wdata_i[i*BANK_DATA_W +: BANK_DATA_W],
      strb_i[i*BANK_STRB_W +: BANK_STRB_W]
    };

    // Writes with no enabled byte never reach this bank.
    assign dead_mask_o[i] = we_i & (strb_i[i*BANK_STRB_W +: BANK_STRB_W] == '0);

    // Per-bank request queue, falls through when empty.
    stream_fifo #(
      .DEPTH (REQ_FIFO_DEPTH),
      .WIDTH (REQ_ITEM_W)
    ) u_req_fifo (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .valid_i (req_fire),
      .ready_o (fifo_ready[i]),
      .data_i  (slice_in[i]),
      .valid_o (head_valid[i]),
      .ready_i (head_pop[i]),
      .data_o  (slice_out[i])
    );

    // Unpack the queue head onto the bank port.
    assign {bank_we_o[i], bank_addr_o[i], bank_wdata_o[i], bank_strb_o[i]} = slice_out[i];

    // Empty-strobe write at the head.
    assign hidden[i] = head_valid[i] & bank_we_o[i] & (bank_strb_o[i] == '0);

    assign bank_req_o[i] = head_valid[i] & ~hidden[i];

    // Hidden slices drop out without waiting for the bank.
    assign head_pop[i] = hidden[i] | bank_gnt_i[i];
  end

  // A waiting wide request holds until it is granted.
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
                   req_i && !gnt_o |=> req_i && $stable({we_i, addr_i, wdata_i, strb_i}))
    else $error("mem_split: request changed before its grant");

endmodule

// ==== resp_join.sv ====
`timescale 1ns/1ps

module resp_join import bank_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  bank_mask_t                 bank_rvalid_i,
  input  bank_data_t [NUM_BANKS-1:0] bank_rdata_i,
  output bank_mask_t                 resp_room_o,
  input  logic                       dead_push_i,
  input  bank_mask_t                 dead_mask_i,
  output logic                       dead_full_o,
  output logic                       rvalid_o,
  output data_t                      rdata_o
);

  bank_mask_t resp_valid;
  bank_mask_t resp_pop;
  bank_mask_t dead_head;
  logic       mask_ready;
  logic       mask_valid;
  logic       mask_take;
  bank_mask_t mask_data;
  logic       head_valid_q;
  bank_mask_t head_mask_q;

  for (genvar i = 0; i < NUM_BANKS; i++) begin : gen_bank
    // Per-bank response queue.
    stream_fifo #(
      .DEPTH (RESP_FIFO_DEPTH),
      .WIDTH (BANK_DATA_W)
    ) u_resp_fifo (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .valid_i (bank_rvalid_i[i]),
      .ready_o (resp_room_o[i]),
      .data_i  (bank_rdata_i[i]),
      .valid_o (resp_valid[i]),
      .ready_i (resp_pop[i]),
      .data_o  (rdata_o[i*BANK_DATA_W +: BANK_DATA_W])
    );

    // Dead banks have nothing queued for this transaction.
    assign resp_pop[i] = rvalid_o & ~dead_head[i];

    // The splitter reserved room before this response left the bank.
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
                     bank_rvalid_i[i] |-> resp_room_o[i])
      else $error("resp_join: bank %0d response into a full queue", i);
  end

  // Dead mask queue.
  stream_fifo #(
    .DEPTH (MAX_TRANS + 1),
    .WIDTH (NUM_BANKS)
  ) u_mask_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (dead_push_i),
    .ready_o (mask_ready),
    .data_i  (dead_mask_i),
    .valid_o (mask_valid),
    .ready_i (mask_take),
    .data_o  (mask_data)
  );

  assign dead_full_o = ~mask_ready;

  // Head register refills when empty or consumed.
  assign mask_take = ~head_valid_q | rvalid_o;

  // The mask shows one cycle after its push.
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      head_valid_q <= 1'b0;
    end else if (mask_take) begin
      head_valid_q <= mask_valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (mask_take && mask_valid) begin
      head_mask_q <= mask_data;
    end
  end

  assign dead_head = head_mask_q & {NUM_BANKS{head_valid_q}};

  // Join when each bank has data or was skipped.
  assign rvalid_o = head_valid_q & (&(resp_valid | dead_head));

endmodule

// ==== sources.f ====
bank_pkg.sv
stream_fifo.sv
mem_split.sv
bank_sram.sv
resp_join.sv
bank_top.sv
tb_bank_top.sv

// ==== stream_fifo.sv ====
`timescale 1ns/1ps

module stream_fifo #(
  parameter int unsigned DEPTH = 2,
  parameter int unsigned WIDTH = 8
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             valid_i,
  output logic             ready_o,
  input  logic [WIDTH-1:0] data_i,
  output logic             valid_o,
  input  logic             ready_i,
  output logic [WIDTH-1:0] data_o
);

  // Pointer and occupancy widths.
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;
  logic             empty;
  logic             push;
  logic             pop;
  logic             store;
  logic             drain;

  // Circular increment.
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign empty = (cnt_q == '0);

  // Room depends only on occupancy.
  assign ready_o = (cnt_q < CNT_W'(DEPTH));

  // Empty queue shows the input directly.
  assign valid_o = empty ? valid_i : 1'b1;
  assign data_o  = empty ? data_i : mem_q[rd_ptr_q];

  assign push = valid_i & ready_o;
  assign pop  = valid_o & ready_i;

  // Item skips storage when it leaves in the same cycle.
  assign store = push & ~(empty & ready_i);
  // Only stored items move the read pointer.
  assign drain = pop & ~empty;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (store) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (drain) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      cnt_q <= cnt_q + CNT_W'(store) - CNT_W'(drain);
    end
  end

  // Payload storage.
  always_ff @(posedge clk_i) begin
    if (store) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // Users of this queue never offer an item it has no room for.
  assert property (@(posedge clk_i) disable iff (!rst_n_i) valid_i |-> ready_o)
    else $error("stream_fifo: item offered while full");

endmodule

// ==== tb_bank_top.sv ====
`timescale 1ns/1ps

module tb_bank_top import bank_pkg::*; ();

  localparam int CLK_PERIOD     = 40;
  localparam int FILL_WORDS     = 16;
  localparam int ALIAS_READS    = 8;
  localparam int PARTIAL_WRITES = 24;
  localparam int EMPTY_WRITES   = 3;
  localparam int MIXED_REQS     = 32;
  // Fill, alias reads, partial writes, empty writes, readback, mixed burst.
  localparam int NUM_REQS       = FILL_WORDS + ALIAS_READS + PARTIAL_WRITES
                                  + EMPTY_WRITES + FILL_WORDS + MIXED_REQS;
  localparam int TIMEOUT_CYCLES = 40 * NUM_REQS + 100;

  // One outstanding request as seen from the wide port.
  typedef struct {
    string name;
    logic  is_read;
    data_t data;
    int    acc_cycle;
    int    exp_lat;
  } exp_t;

  logic  clk_i;
  logic  rst_n_i;
  logic  req_i;
  logic  we_i;
  addr_t addr_i;
  data_t wdata_i;
  strb_t strb_i;
  logic  gnt_o;
  logic  rvalid_o;
  data_t rdata_o;

  // Byte-wide reference memory, one row of WIDE_BYTES per word.
  logic [7:0] ref_mem [BANK_WORDS*WIDE_BYTES];
  exp_t       exp_q [$];

  int cycle_cnt = 0;
  int seed;
  int data_err;
  int lat_err;
  int order_err;
  int proto_err;
  int accept_cnt;
  int resp_cnt;
  bit gnt_drop_seen;
  bit gnt_rise_seen;

  bank_top dut (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .req_i    (req_i),
    .we_i     (we_i),
    .addr_i   (addr_i),
    .wdata_i  (wdata_i),
    .strb_i   (strb_i),
    .gnt_o    (gnt_o),
    .rvalid_o (rvalid_o),
    .rdata_o  (rdata_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD/2) clk_i = ~clk_i;
  end

  always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

  // Word slot: byte address over the wide word size, wrapped by the bank depth.
  function automatic int word_base(input addr_t addr);
    return ((int'(addr) / WIDE_BYTES) % BANK_WORDS) * WIDE_BYTES;
  endfunction

  function automatic data_t model_read(input addr_t addr);
    int    base;
    data_t d;
    base = word_base(addr);
    for (int b = 0; b < WIDE_BYTES; b++) begin
      d[8*b +: 8] = ref_mem[base + b];
    end
    return d;
  endfunction

  // Only strobed bytes change.
  function automatic void model_write(input addr_t addr, input data_t wdata, input strb_t strb);
    int base;
    base = word_base(addr);
    for (int b = 0; b < WIDE_BYTES; b++) begin
      if (strb[b]) begin
        ref_mem[base + b] = wdata[8*b +: 8];
      end
    end
  endfunction

  // Every lane is tied to the full address.
  function automatic data_t fill_pattern(input addr_t addr);
    return {addr ^ 16'hA5C3, addr + 16'h0F0F, ~addr, addr};
  endfunction

  // Random strobe, with whole bank lanes cleared now and then.
  function automatic strb_t random_strobe();
    strb_t s;
    s = strb_t'($random(seed));
    for (int i = 0; i < NUM_BANKS; i++) begin
      if (($random(seed) & 3) == 0) begin
        s[i*BANK_STRB_W +: BANK_STRB_W] = '0;
      end
    end
    return s;
  endfunction

  function automatic data_t random_data();
    return {$random(seed), $random(seed)};
  endfunction

  // Drive on the falling edge, hold until a rising edge sees the grant.
  task automatic send_request(input string name, input logic we, input addr_t addr,
                              input data_t wdata, input strb_t strb);
    logic granted;
    int   acc_cycle;
    exp_t e;
    @(negedge clk_i);
    req_i   = 1'b1;
    we_i    = we;
    addr_i  = addr;
    wdata_i = wdata;
    strb_i  = strb;
    // Grant only depends on queue state, so it is settled here.
    granted   = gnt_o;
    acc_cycle = cycle_cnt;
    while (!granted) begin
      gnt_drop_seen = 1'b1;
      @(negedge clk_i);
      granted   = gnt_o;
      acc_cycle = cycle_cnt;
    end
    if (gnt_drop_seen) begin
      gnt_rise_seen = 1'b1;
    end
    @(posedge clk_i);
    e.name      = name;
    e.is_read   = ~we;
    e.acc_cycle = acc_cycle;
    // Fixed latency only applies when nothing is in flight.
    if (exp_q.size() == 0) begin
      e.exp_lat = (we && strb == '0) ? 1 : 2;
    end else begin
      e.exp_lat = 0;
    end
    e.data = model_read(addr);
    if (we) begin
      model_write(addr, wdata, strb);
    end
    exp_q.push_back(e);
    accept_cnt++;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge clk_i);
      req_i = 1'b0;
    end
  endtask

  task automatic wait_drain();
    @(negedge clk_i);
    req_i = 1'b0;
    while (exp_q.size() != 0) @(negedge clk_i);
  endtask

  // Response checker, outputs are stable at the falling edge.
  always @(negedge clk_i) begin : monitor
    exp_t e;
    int   lat;
    if (rst_n_i === 1'b1 && rvalid_o === 1'b1) begin
      resp_cnt++;
      assert (exp_q.size() != 0)
        else begin
          order_err++;
          $display("rvalid_o pulsed with no request outstanding at cycle %0d", cycle_cnt);
        end
      if (exp_q.size() != 0) begin
        e   = exp_q.pop_front();
        lat = cycle_cnt - e.acc_cycle;
        if (e.is_read) begin
          assert (rdata_o === e.data)
            else begin
              data_err++;
              $display("[ERROR] %s: expected %h, actual %h", e.name, e.data, rdata_o);
            end
        end
        if (e.exp_lat != 0) begin
          assert (lat == e.exp_lat)
            else begin
              lat_err++;
              $display("[ERROR] %s latency: expected %0d, actual %0d", e.name, e.exp_lat, lat);
            end
        end
      end
    end
  end

  // Outputs are never unknown once reset is released.
  assert property (@(posedge clk_i) disable iff (!rst_n_i) !$isunknown({gnt_o, rvalid_o}))
    else begin
      proto_err++;
      $display("gnt_o or rvalid_o went unknown at cycle %0d", cycle_cnt);
    end

  initial begin : watchdog
    while (cycle_cnt < TIMEOUT_CYCLES) @(posedge clk_i);
    $display("Run timed out after %0d cycles with %0d responses outstanding",
             cycle_cnt, exp_q.size());
    $display("Test failed");
    $finish;
  end

  initial begin : stimulus
    addr_t a;
    int    w;
    int    r;
    seed    = 18;
    rst_n_i = 1'b0;
    req_i   = 1'b0;
    we_i    = 1'b0;
    addr_i  = '0;
    wdata_i = '0;
    strb_i  = '0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;

    // Idle state after reset.
    @(negedge clk_i);
    assert (gnt_o === 1'b1)
      else begin
        proto_err++;
        $display("[ERROR] reset gnt_o: expected 1, actual %b", gnt_o);
      end
    assert (rvalid_o === 1'b0)
      else begin
        proto_err++;
        $display("[ERROR] reset rvalid_o: expected 0, actual %b", rvalid_o);
      end

    // Full-strobe fill, back to back.
    for (int i = 0; i < FILL_WORDS; i++) begin
      a = addr_t'(i * WIDE_BYTES);
      send_request("fill", 1'b1, a, fill_pattern(a), '1);
    end
    wait_drain();

    // Low address bits and the bank wrap still reach the same word.
    for (int i = 0; i < ALIAS_READS; i++) begin
      a = addr_t'(2 * i * WIDE_BYTES + i + (i % 2) * BANK_WORDS * WIDE_BYTES);
      send_request("alias_read", 1'b0, a, '0, '0);
      wait_drain();
    end

    // Partial writes with random gaps.
    for (int i = 0; i < PARTIAL_WRITES; i++) begin
      w = $random(seed) & (FILL_WORDS - 1);
      a = addr_t'(w * WIDE_BYTES + ($random(seed) & 7));
      send_request("partial_write", 1'b1, a, random_data(), random_strobe());
      idle_cycles($random(seed) & 1);
    end
    wait_drain();

    // No bank sees these, the joiner answers alone.
    for (int i = 0; i < EMPTY_WRITES; i++) begin
      a = addr_t'(3 * i * WIDE_BYTES);
      send_request("empty_write", 1'b1, a, random_data(), '0);
      wait_drain();
    end

    // Readback burst fills the request queues.
    for (int i = 0; i < FILL_WORDS; i++) begin
      send_request("readback", 1'b0, addr_t'(i * WIDE_BYTES), '0, '0);
    end
    wait_drain();

    // Mixed reads and writes, back to back.
    for (int i = 0; i < MIXED_REQS; i++) begin
      r = $random(seed);
      w = r & (FILL_WORDS - 1);
      a = addr_t'(w * WIDE_BYTES + ((r >> 4) & 7) + ((r >> 7) & 1) * BANK_WORDS * WIDE_BYTES);
      send_request("mixed", r[8], a, random_data(), random_strobe());
    end
    wait_drain();

    // Quiet period catches stray responses.
    repeat (5) @(negedge clk_i);

    assert (gnt_drop_seen && gnt_rise_seen)
      else begin
        proto_err++;
        $display("gnt_o never stalled and recovered during back-to-back requests");
      end
    assert (resp_cnt == accept_cnt)
      else begin
        order_err++;
        $display("[ERROR] response count: expected %0d, actual %0d", accept_cnt, resp_cnt);
      end

    $display("Requests %0d, responses %0d, data errors %0d, latency errors %0d, %s %0d, %s %0d",
             accept_cnt, resp_cnt, data_err, lat_err, "order errors", order_err,
             "protocol errors", proto_err);
    if (data_err + lat_err + order_err + proto_err == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
